/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps
TOP       ?= tb_id_stage
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* dv/id_ref_model.svh */
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

rv32i_pkg::word_t       shadow_regs [32]; // Mirror of the architectural registers

// Expected ID/EX contents, held until the next compare
logic                   exp_valid, exp_mem_read, exp_mem_write, exp_regf_we;
rv32i_pkg::word_t       exp_pc, exp_inst, exp_imm, exp_rs1_v, exp_rs2_v;
rv32i_pkg::order_t      exp_order;
rv32i_pkg::alu_m1_sel_t exp_alu_m1_sel;
rv32i_pkg::alu_m2_sel_t exp_alu_m2_sel;
rv32i_pkg::alu_op_t     exp_alu_op;
rv32i_pkg::cmp_m_sel_t  exp_cmp_m_sel;
rv32i_pkg::cmp_op_t     exp_cmp_op;
rv32i_pkg::regf_m_sel_t exp_regf_m_sel;

task automatic clear_shadow();
    foreach (shadow_regs[r]) begin
        shadow_regs[r] = '0;
    end
endtask

task automatic apply_writeback(input logic we, input rv32i_pkg::reg_idx_t rd,
                               input rv32i_pkg::word_t v);
    if (we && rd != 5'd0) begin
        shadow_regs[rd] = v;
    end
endtask

// Same-cycle writeback beats the stored copy
function automatic rv32i_pkg::word_t read_operand(input rv32i_pkg::reg_idx_t idx,
                                                  input logic we,
                                                  input rv32i_pkg::reg_idx_t rd,
                                                  input rv32i_pkg::word_t v);
    if (idx == 5'd0) begin
        return '0;
    end
    if (we && rd == idx) begin
        return v;
    end
    return shadow_regs[idx];
endfunction

task automatic predict_decode(input logic resp, input rv32i_pkg::word_t inst,
                              input rv32i_pkg::word_t pc, input rv32i_pkg::order_t order,
                              input logic wb_we, input rv32i_pkg::reg_idx_t wb_rd,
                              input rv32i_pkg::word_t wb_v);
    rv32i_pkg::opcode_t op;
    rv32i_pkg::funct3_t f3;
    logic               alt;
    op = inst[6:0];
    f3 = inst[14:12];
    alt = inst[30];
    exp_valid = resp;
    exp_pc = pc;
    exp_order = order;
    exp_inst = inst;
    exp_rs1_v = read_operand(inst[19:15], wb_we, wb_rd, wb_v);
    exp_rs2_v = read_operand(inst[24:20], wb_we, wb_rd, wb_v);
    exp_imm = '0;
    exp_alu_m1_sel = rv32i_pkg::M1_RS1_V;
    exp_alu_m2_sel = rv32i_pkg::M2_RS2_V;
    exp_alu_op = rv32i_pkg::ALU_ADD;
    exp_cmp_m_sel = rv32i_pkg::CMP_RS2_V;
    exp_cmp_op = '0;
    exp_mem_read = 1'b0;
    exp_mem_write = 1'b0;
    exp_regf_m_sel = rv32i_pkg::WB_ALU;
    exp_regf_we = 1'b0;
    if (resp) begin
        case (op)
            rv32i_pkg::OP_LUI: begin
                exp_imm = {inst[31:12], 12'h000};
                exp_regf_m_sel = rv32i_pkg::WB_UIMM;
                exp_regf_we = 1'b1;
            end
            rv32i_pkg::OP_AUIPC: begin
                exp_imm = {inst[31:12], 12'h000};
                exp_alu_m1_sel = rv32i_pkg::M1_PC;
                exp_alu_m2_sel = rv32i_pkg::M2_IMM;
                exp_regf_we = 1'b1;
            end
            rv32i_pkg::OP_IMM, rv32i_pkg::OP_REG: begin
                exp_regf_we = 1'b1;
                if (op == rv32i_pkg::OP_IMM) begin
                    exp_imm = {{20{inst[31]}}, inst[31:20]};
                end
                if (f3 == rv32i_pkg::F3_SLT || f3 == rv32i_pkg::F3_SLTU) begin
                    exp_cmp_m_sel = (op == rv32i_pkg::OP_IMM) ? rv32i_pkg::CMP_IMM
                                                              : rv32i_pkg::CMP_RS2_V;
                    exp_cmp_op = (f3 == rv32i_pkg::F3_SLT) ? rv32i_pkg::CMP_BLT
                                                           : rv32i_pkg::CMP_BLTU;
                    exp_regf_m_sel = rv32i_pkg::WB_CMP;
                end else begin
                    exp_alu_m2_sel = (op == rv32i_pkg::OP_IMM) ? rv32i_pkg::M2_IMM
                                                               : rv32i_pkg::M2_RS2_V;
                    case (f3)
                        rv32i_pkg::F3_ADD: exp_alu_op = (alt && op == rv32i_pkg::OP_REG)
                                                        ? rv32i_pkg::ALU_SUB : rv32i_pkg::ALU_ADD;
                        rv32i_pkg::F3_SLL: exp_alu_op = rv32i_pkg::ALU_SLL;
                        rv32i_pkg::F3_XOR: exp_alu_op = rv32i_pkg::ALU_XOR;
                        rv32i_pkg::F3_SR:  exp_alu_op = alt ? rv32i_pkg::ALU_SRA
                                                            : rv32i_pkg::ALU_SRL;
                        rv32i_pkg::F3_OR:  exp_alu_op = rv32i_pkg::ALU_OR;
                        default:           exp_alu_op = rv32i_pkg::ALU_AND;
                    endcase
                end
            end
            rv32i_pkg::OP_LOAD: begin
                exp_imm = {{20{inst[31]}}, inst[31:20]};
                exp_alu_m2_sel = rv32i_pkg::M2_IMM;
                exp_mem_read = 1'b1;
                exp_regf_we = 1'b1;
                case (f3)
                    rv32i_pkg::F3_LB:  exp_regf_m_sel = rv32i_pkg::WB_LB;
                    rv32i_pkg::F3_LH:  exp_regf_m_sel = rv32i_pkg::WB_LH;
                    rv32i_pkg::F3_LW:  exp_regf_m_sel = rv32i_pkg::WB_LW;
                    rv32i_pkg::F3_LBU: exp_regf_m_sel = rv32i_pkg::WB_LBU;
                    rv32i_pkg::F3_LHU: exp_regf_m_sel = rv32i_pkg::WB_LHU;
                    default:           exp_regf_m_sel = rv32i_pkg::WB_ALU; // Reserved width
                endcase
            end
            rv32i_pkg::OP_STORE: begin
                exp_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                exp_alu_m2_sel = rv32i_pkg::M2_IMM;
                exp_mem_write = 1'b1;
            end
            default: begin
                exp_imm = '0; // Unsupported opcode
            end
        endcase
    end
endtask

`endif

/* dv/tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage;

    localparam int RESET_CYCLES = 8;
    localparam int N_WORDS      = 2000;
    localparam int CYCLE_LIMIT  = N_WORDS + 100 + RESET_CYCLES;

    logic                   clk = 1'b0;
    logic                   i_rst_n, i_imem_resp, i_wb_regf_we;
    rv32i_pkg::word_t       i_imem_rdata, i_pc, i_wb_rd_v;
    rv32i_pkg::order_t      i_order;
    rv32i_pkg::reg_idx_t    i_wb_rd_s;
    logic                   o_valid, o_mem_read, o_mem_write, o_regf_we;
    rv32i_pkg::word_t       o_pc, o_inst, o_rs1_v, o_rs2_v, o_imm;
    rv32i_pkg::order_t      o_order;
    rv32i_pkg::reg_idx_t    o_rs1_s, o_rs2_s, o_rd_s;
    rv32i_pkg::funct3_t     o_funct3;
    rv32i_pkg::alu_m1_sel_t o_alu_m1_sel;
    rv32i_pkg::alu_m2_sel_t o_alu_m2_sel;
    rv32i_pkg::alu_op_t     o_alu_op;
    rv32i_pkg::cmp_m_sel_t  o_cmp_m_sel;
    rv32i_pkg::cmp_op_t     o_cmp_op;
    rv32i_pkg::regf_m_sel_t o_regf_m_sel;

    logic [31:0]            lfsr_state;
    rv32i_pkg::order_t      next_order;
    int                     cycle_count = 0;

    `include "id_ref_model.svh"

    id_stage u_dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $fatal(1, "Timeout");
        end
    end

    // Galois LFSR
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int k = 0; k < n; k++) begin
            b          = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h80200003 : 32'h0);
            v          = {v[30:0], b};
        end
        return v;
    endfunction

    task automatic drive_next_word();
        rv32i_pkg::word_t   inst;
        rv32i_pkg::opcode_t op;
        logic [2:0]         pick;
        logic [1:0]         aim;
        pick = 3'(take_bits(3));
        case (pick)
            3'd0:    op = rv32i_pkg::OP_LUI;
            3'd1:    op = rv32i_pkg::OP_AUIPC;
            3'd2:    op = rv32i_pkg::OP_IMM;
            3'd3:    op = rv32i_pkg::OP_REG;
            3'd4:    op = rv32i_pkg::OP_LOAD;
            3'd5:    op = rv32i_pkg::OP_STORE;
            default: op = 7'b1100011; // Branch, not decoded here
        endcase
        inst = (take_bits(25) << 7) | {25'h0, op};
        i_imem_rdata <= inst;
        i_imem_resp  <= (take_bits(3) != 0); // About 7 in 8
        i_pc         <= take_bits(30) << 2;
        i_order      <= next_order;
        i_wb_regf_we <= (take_bits(1) != 0);
        aim = 2'(take_bits(2));
        if (aim == 2'd0) begin
            i_wb_rd_s <= inst[19:15]; // Hit forwarding on rs1
        end else if (aim == 2'd1) begin
            i_wb_rd_s <= inst[24:20];
        end else begin
            i_wb_rd_s <= 5'(take_bits(5));
        end
        i_wb_rd_v    <= take_bits(32);
        next_order   = next_order + 64'd1;
    endtask

    task automatic stop_on_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_word(input string name, input rv32i_pkg::word_t got,
                              input rv32i_pkg::word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_idx(input string name, input rv32i_pkg::reg_idx_t got,
                             input rv32i_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_order(input string name, input rv32i_pkg::order_t got,
                               input rv32i_pkg::order_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_funct3(input string name, input rv32i_pkg::funct3_t got,
                                input rv32i_pkg::funct3_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_code(input string name, input rv32i_pkg::alu_op_t got,
                              input rv32i_pkg::alu_op_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_cmp_op(input string name, input rv32i_pkg::cmp_op_t got,
                                input rv32i_pkg::cmp_op_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_m1_sel(input string name, input rv32i_pkg::alu_m1_sel_t got,
                                input rv32i_pkg::alu_m1_sel_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_m2_sel(input string name, input rv32i_pkg::alu_m2_sel_t got,
                                input rv32i_pkg::alu_m2_sel_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_cmp_sel(input string name, input rv32i_pkg::cmp_m_sel_t got,
                                 input rv32i_pkg::cmp_m_sel_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_sel(input string name, input rv32i_pkg::regf_m_sel_t got,
                             input rv32i_pkg::regf_m_sel_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic compare_outputs();
        check_flag("o_valid", o_valid, exp_valid);
        check_word("o_pc", o_pc, exp_pc);
        check_order("o_order", o_order, exp_order);
        check_word("o_inst", o_inst, exp_inst);
        check_idx("o_rs1_s", o_rs1_s, exp_inst[19:15]);
        check_idx("o_rs2_s", o_rs2_s, exp_inst[24:20]);
        check_idx("o_rd_s", o_rd_s, exp_inst[11:7]);
        check_word("o_rs1_v", o_rs1_v, exp_rs1_v);
        check_word("o_rs2_v", o_rs2_v, exp_rs2_v);
        check_word("o_imm", o_imm, exp_imm);
        check_funct3("o_funct3", o_funct3, exp_inst[14:12]);
        check_m1_sel("o_alu_m1_sel", o_alu_m1_sel, exp_alu_m1_sel);
        check_m2_sel("o_alu_m2_sel", o_alu_m2_sel, exp_alu_m2_sel);
        check_code("o_alu_op", o_alu_op, exp_alu_op);
        check_cmp_sel("o_cmp_m_sel", o_cmp_m_sel, exp_cmp_m_sel);
        check_cmp_op("o_cmp_op", o_cmp_op, exp_cmp_op);
        check_flag("o_mem_read", o_mem_read, exp_mem_read);
        check_flag("o_mem_write", o_mem_write, exp_mem_write);
        check_sel("o_regf_m_sel", o_regf_m_sel, exp_regf_m_sel);
        check_flag("o_regf_we", o_regf_we, exp_regf_we);
    endtask

    initial begin
        lfsr_state   = 32'h4aa5153c;
        next_order   = '0;
        i_rst_n      <= 1'b0;
        i_imem_resp  <= 1'b0;
        i_imem_rdata <= '0;
        i_pc         <= '0;
        i_order      <= '0;
        i_wb_regf_we <= 1'b0;
        i_wb_rd_s    <= '0;
        i_wb_rd_v    <= '0;
        clear_shadow();
        predict_decode(1'b0, '0, '0, '0, 1'b0, '0, '0); // Reset leaves all outputs at zero
        repeat (RESET_CYCLES) @(posedge clk);
        i_rst_n <= 1'b1;
        @(negedge clk);
        for (int n = 0; n < N_WORDS; n++) begin
            compare_outputs();
            predict_decode(i_imem_resp, i_imem_rdata, i_pc, i_order,
                           i_wb_regf_we, i_wb_rd_s, i_wb_rd_v);
            apply_writeback(i_wb_regf_we, i_wb_rd_s, i_wb_rd_v); // Lands at the next edge
            @(posedge clk);
            drive_next_word();
            @(negedge clk);
        end
        compare_outputs();
        predict_decode(i_imem_resp, i_imem_rdata, i_pc, i_order,
                       i_wb_regf_we, i_wb_rd_s, i_wb_rd_v);
        @(posedge clk);
        @(negedge clk);
        compare_outputs();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* rtl/id_decoder.sv */
`timescale 1ns/1ps

module id_decoder (
    input  logic                   i_imem_resp,
    input  rv32i_pkg::word_t       i_inst,
    output rv32i_pkg::reg_idx_t    o_rs1_s,
    output rv32i_pkg::reg_idx_t    o_rs2_s,
    output rv32i_pkg::reg_idx_t    o_rd_s,
    output rv32i_pkg::funct3_t     o_funct3,
    output rv32i_pkg::word_t       o_imm,
    output rv32i_pkg::alu_m1_sel_t o_alu_m1_sel,
    output rv32i_pkg::alu_m2_sel_t o_alu_m2_sel,
    output rv32i_pkg::alu_op_t     o_alu_op,
    output rv32i_pkg::cmp_m_sel_t  o_cmp_m_sel,
    output rv32i_pkg::cmp_op_t     o_cmp_op,
    output logic                   o_mem_read,
    output logic                   o_mem_write,
    output rv32i_pkg::regf_m_sel_t o_regf_m_sel,
    output logic                   o_regf_we
);

    rv32i_pkg::opcode_t opcode;
    rv32i_pkg::funct3_t funct3;
    logic               funct7_b5;
    logic               is_imm;
    rv32i_pkg::word_t   i_imm;
    rv32i_pkg::word_t   s_imm;
    rv32i_pkg::word_t   u_imm;

    assign opcode    = i_inst[6:0];
    assign funct3    = i_inst[14:12];
    assign funct7_b5 = i_inst[30];
    assign is_imm    = (opcode == rv32i_pkg::OP_IMM);

    assign o_rs1_s  = i_inst[19:15];
    assign o_rs2_s  = i_inst[24:20];
    assign o_rd_s   = i_inst[11:7];
    assign o_funct3 = funct3;

    assign i_imm = {{21{i_inst[31]}}, i_inst[30:20]};
    assign s_imm = {{21{i_inst[31]}}, i_inst[30:25], i_inst[11:7]};
    assign u_imm = {i_inst[31:12], 12'h000};

    always_comb begin
        // Unused selects stay at zero
        o_imm        = '0;
        o_alu_m1_sel = rv32i_pkg::M1_RS1_V;
        o_alu_m2_sel = rv32i_pkg::M2_RS2_V;
        o_alu_op     = rv32i_pkg::ALU_ADD;
        o_cmp_m_sel  = rv32i_pkg::CMP_RS2_V;
        o_cmp_op     = '0;
        o_mem_read   = 1'b0;
        o_mem_write  = 1'b0;
        o_regf_m_sel = rv32i_pkg::WB_ALU;
        o_regf_we    = 1'b0;

        if (i_imem_resp) begin
            case (opcode)
                rv32i_pkg::OP_LUI: begin
                    o_imm        = u_imm;
                    o_regf_m_sel = rv32i_pkg::WB_UIMM;
                    o_regf_we    = 1'b1;
                end
                rv32i_pkg::OP_AUIPC: begin
                    o_imm        = u_imm;
                    o_alu_m1_sel = rv32i_pkg::M1_PC;
                    o_alu_m2_sel = rv32i_pkg::M2_IMM;
                    o_regf_we    = 1'b1;
                end
                rv32i_pkg::OP_IMM, rv32i_pkg::OP_REG: begin
                    o_regf_we = 1'b1;
                    if (is_imm) begin
                        o_imm = i_imm;
                    end
                    case (funct3)
                        rv32i_pkg::F3_SLT, rv32i_pkg::F3_SLTU: begin
                            o_cmp_m_sel  = is_imm ? rv32i_pkg::CMP_IMM : rv32i_pkg::CMP_RS2_V;
                            o_cmp_op     = (funct3 == rv32i_pkg::F3_SLT) ? rv32i_pkg::CMP_BLT
                                                                         : rv32i_pkg::CMP_BLTU;
                            o_regf_m_sel = rv32i_pkg::WB_CMP;
                        end
                        default: begin
                            o_alu_m2_sel = is_imm ? rv32i_pkg::M2_IMM : rv32i_pkg::M2_RS2_V;
                            o_alu_op     = funct3; // Direct funct3 to ALU code
                            if (funct3 == rv32i_pkg::F3_SR && funct7_b5) begin
                                o_alu_op = rv32i_pkg::ALU_SRA;
                            end
                            if (funct3 == rv32i_pkg::F3_ADD && funct7_b5 && !is_imm) begin
                                o_alu_op = rv32i_pkg::ALU_SUB; // No SUBI in RV32I
                            end
                        end
                    endcase
                end
                rv32i_pkg::OP_LOAD: begin
                    o_imm        = i_imm;
                    o_alu_m2_sel = rv32i_pkg::M2_IMM;
                    o_mem_read   = 1'b1;
                    o_regf_we    = 1'b1;
                    case (funct3)
                        rv32i_pkg::F3_LB:  o_regf_m_sel = rv32i_pkg::WB_LB;
                        rv32i_pkg::F3_LH:  o_regf_m_sel = rv32i_pkg::WB_LH;
                        rv32i_pkg::F3_LW:  o_regf_m_sel = rv32i_pkg::WB_LW;
                        rv32i_pkg::F3_LBU: o_regf_m_sel = rv32i_pkg::WB_LBU;
                        rv32i_pkg::F3_LHU: o_regf_m_sel = rv32i_pkg::WB_LHU;
                        default:           o_regf_m_sel = rv32i_pkg::WB_ALU;
                    endcase
                end
                rv32i_pkg::OP_STORE: begin
                    o_imm        = s_imm;
                    o_alu_m2_sel = rv32i_pkg::M2_IMM;
                    o_mem_write  = 1'b1; // Width travels on funct3
                end
                default: begin
                    o_imm = '0;
                end
            endcase
        end
    end

endmodule

/* rtl/id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_valid,
    input  rv32i_pkg::word_t       i_pc,
    input  rv32i_pkg::order_t      i_order,
    input  rv32i_pkg::word_t       i_inst,
    input  rv32i_pkg::reg_idx_t    i_rs1_s,
    input  rv32i_pkg::reg_idx_t    i_rs2_s,
    input  rv32i_pkg::reg_idx_t    i_rd_s,
    input  rv32i_pkg::funct3_t     i_funct3,
    input  rv32i_pkg::word_t       i_imm,
    input  rv32i_pkg::alu_m1_sel_t i_alu_m1_sel,
    input  rv32i_pkg::alu_m2_sel_t i_alu_m2_sel,
    input  rv32i_pkg::alu_op_t     i_alu_op,
    input  rv32i_pkg::cmp_m_sel_t  i_cmp_m_sel,
    input  rv32i_pkg::cmp_op_t     i_cmp_op,
    input  logic                   i_mem_read,
    input  logic                   i_mem_write,
    input  rv32i_pkg::regf_m_sel_t i_regf_m_sel,
    input  logic                   i_regf_we,
    input  rv32i_pkg::word_t       i_rs1_v,
    input  rv32i_pkg::word_t       i_rs2_v,
    input  logic                   i_wb_we,
    input  rv32i_pkg::reg_idx_t    i_wb_rd_s,
    input  rv32i_pkg::word_t       i_wb_rd_v,
    output logic                   o_valid,
    output rv32i_pkg::word_t       o_pc,
    output rv32i_pkg::order_t      o_order,
    output rv32i_pkg::word_t       o_inst,
    output rv32i_pkg::reg_idx_t    o_rs1_s,
    output rv32i_pkg::reg_idx_t    o_rs2_s,
    output rv32i_pkg::reg_idx_t    o_rd_s,
    output rv32i_pkg::word_t       o_rs1_v,
    output rv32i_pkg::word_t       o_rs2_v,
    output rv32i_pkg::word_t       o_imm,
    output rv32i_pkg::funct3_t     o_funct3,
    output rv32i_pkg::alu_m1_sel_t o_alu_m1_sel,
    output rv32i_pkg::alu_m2_sel_t o_alu_m2_sel,
    output rv32i_pkg::alu_op_t     o_alu_op,
    output rv32i_pkg::cmp_m_sel_t  o_cmp_m_sel,
    output rv32i_pkg::cmp_op_t     o_cmp_op,
    output logic                   o_mem_read,
    output logic                   o_mem_write,
    output rv32i_pkg::regf_m_sel_t o_regf_m_sel,
    output logic                   o_regf_we
);

    rv32i_pkg::word_t rs1_fwd;
    rv32i_pkg::word_t rs2_fwd;

    // Writeback in the same cycle wins over the stored value
    function automatic rv32i_pkg::word_t fwd_value(
        input logic                wb_we,
        input rv32i_pkg::reg_idx_t wb_rd_s,
        input rv32i_pkg::word_t    wb_rd_v,
        input rv32i_pkg::reg_idx_t src_s,
        input rv32i_pkg::word_t    src_v
    );
        if (wb_we && (wb_rd_s != '0) && (wb_rd_s == src_s)) begin
            return wb_rd_v;
        end
        return src_v;
    endfunction

    assign rs1_fwd = fwd_value(i_wb_we, i_wb_rd_s, i_wb_rd_v, i_rs1_s, i_rs1_v);
    assign rs2_fwd = fwd_value(i_wb_we, i_wb_rd_s, i_wb_rd_v, i_rs2_s, i_rs2_v);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_valid      <= 1'b0;
            o_pc         <= '0;
            o_order      <= '0;
            o_inst       <= '0;
            o_rs1_s      <= '0;
            o_rs2_s      <= '0;
            o_rd_s       <= '0;
            o_rs1_v      <= '0;
            o_rs2_v      <= '0;
            o_imm        <= '0;
            o_funct3     <= '0;
            o_alu_m1_sel <= '0;
            o_alu_m2_sel <= '0;
            o_alu_op     <= '0;
            o_cmp_m_sel  <= '0;
            o_cmp_op     <= '0;
            o_mem_read   <= 1'b0;
            o_mem_write  <= 1'b0;
            o_regf_m_sel <= '0;
            o_regf_we    <= 1'b0;
        end else begin
            o_valid      <= i_valid;
            o_pc         <= i_pc;
            o_order      <= i_order;
            o_inst       <= i_inst;
            o_rs1_s      <= i_rs1_s;
            o_rs2_s      <= i_rs2_s;
            o_rd_s       <= i_rd_s;
            o_rs1_v      <= rs1_fwd;
            o_rs2_v      <= rs2_fwd;
            o_imm        <= i_imm;
            o_funct3     <= i_funct3;
            o_alu_m1_sel <= i_alu_m1_sel;
            o_alu_m2_sel <= i_alu_m2_sel;
            o_alu_op     <= i_alu_op;
            o_cmp_m_sel  <= i_cmp_m_sel;
            o_cmp_op     <= i_cmp_op;
            o_mem_read   <= i_mem_read;
            o_mem_write  <= i_mem_write;
            o_regf_m_sel <= i_regf_m_sel;
            o_regf_we    <= i_regf_we;
        end
    end

endmodule

/* rtl/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_imem_resp,
    input  rv32i_pkg::word_t       i_imem_rdata,
    input  rv32i_pkg::word_t       i_pc,
    input  rv32i_pkg::order_t      i_order,
    input  logic                   i_wb_regf_we,
    input  rv32i_pkg::reg_idx_t    i_wb_rd_s,
    input  rv32i_pkg::word_t       i_wb_rd_v,
    output logic                   o_valid,
    output rv32i_pkg::word_t       o_pc,
    output rv32i_pkg::order_t      o_order,
    output rv32i_pkg::word_t       o_inst,
    output rv32i_pkg::reg_idx_t    o_rs1_s,
    output rv32i_pkg::reg_idx_t    o_rs2_s,
    output rv32i_pkg::reg_idx_t    o_rd_s,
    output rv32i_pkg::word_t       o_rs1_v,
    output rv32i_pkg::word_t       o_rs2_v,
    output rv32i_pkg::word_t       o_imm,
    output rv32i_pkg::funct3_t     o_funct3,
    output rv32i_pkg::alu_m1_sel_t o_alu_m1_sel,
    output rv32i_pkg::alu_m2_sel_t o_alu_m2_sel,
    output rv32i_pkg::alu_op_t     o_alu_op,
    output rv32i_pkg::cmp_m_sel_t  o_cmp_m_sel,
    output rv32i_pkg::cmp_op_t     o_cmp_op,
    output logic                   o_mem_read,
    output logic                   o_mem_write,
    output rv32i_pkg::regf_m_sel_t o_regf_m_sel,
    output logic                   o_regf_we
);

    rv32i_pkg::reg_idx_t    dec_rs1_s;
    rv32i_pkg::reg_idx_t    dec_rs2_s;
    rv32i_pkg::reg_idx_t    dec_rd_s;
    rv32i_pkg::funct3_t     dec_funct3;
    rv32i_pkg::word_t       dec_imm;
    rv32i_pkg::alu_m1_sel_t dec_alu_m1_sel;
    rv32i_pkg::alu_m2_sel_t dec_alu_m2_sel;
    rv32i_pkg::alu_op_t     dec_alu_op;
    rv32i_pkg::cmp_m_sel_t  dec_cmp_m_sel;
    rv32i_pkg::cmp_op_t     dec_cmp_op;
    logic                   dec_mem_read;
    logic                   dec_mem_write;
    rv32i_pkg::regf_m_sel_t dec_regf_m_sel;
    logic                   dec_regf_we;
    rv32i_pkg::word_t       rf_rs1_v;
    rv32i_pkg::word_t       rf_rs2_v;

    id_decoder u_decoder (
        .i_imem_resp  (i_imem_resp),
        .i_inst       (i_imem_rdata),
        .o_rs1_s      (dec_rs1_s),
        .o_rs2_s      (dec_rs2_s),
        .o_rd_s       (dec_rd_s),
        .o_funct3     (dec_funct3),
        .o_imm        (dec_imm),
        .o_alu_m1_sel (dec_alu_m1_sel),
        .o_alu_m2_sel (dec_alu_m2_sel),
        .o_alu_op     (dec_alu_op),
        .o_cmp_m_sel  (dec_cmp_m_sel),
        .o_cmp_op     (dec_cmp_op),
        .o_mem_read   (dec_mem_read),
        .o_mem_write  (dec_mem_write),
        .o_regf_m_sel (dec_regf_m_sel),
        .o_regf_we    (dec_regf_we)
    );

    regfile u_regfile (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_we    (i_wb_regf_we),
        .i_rd_s  (i_wb_rd_s),
        .i_rd_v  (i_wb_rd_v),
        .i_rs1_s (dec_rs1_s),
        .i_rs2_s (dec_rs2_s),
        .o_rs1_v (rf_rs1_v),
        .o_rs2_v (rf_rs2_v)
    );

    id_ex_reg u_id_ex (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_imem_resp),
        .i_pc         (i_pc),
        .i_order      (i_order),
        .i_inst       (i_imem_rdata),
        .i_rs1_s      (dec_rs1_s),
        .i_rs2_s      (dec_rs2_s),
        .i_rd_s       (dec_rd_s),
        .i_funct3     (dec_funct3),
        .i_imm        (dec_imm),
        .i_alu_m1_sel (dec_alu_m1_sel),
        .i_alu_m2_sel (dec_alu_m2_sel),
        .i_alu_op     (dec_alu_op),
        .i_cmp_m_sel  (dec_cmp_m_sel),
        .i_cmp_op     (dec_cmp_op),
        .i_mem_read   (dec_mem_read),
        .i_mem_write  (dec_mem_write),
        .i_regf_m_sel (dec_regf_m_sel),
        .i_regf_we    (dec_regf_we),
        .i_rs1_v      (rf_rs1_v),
        .i_rs2_v      (rf_rs2_v),
        .i_wb_we      (i_wb_regf_we),
        .i_wb_rd_s    (i_wb_rd_s),
        .i_wb_rd_v    (i_wb_rd_v),
        .o_valid      (o_valid),
        .o_pc         (o_pc),
        .o_order      (o_order),
        .o_inst       (o_inst),
        .o_rs1_s      (o_rs1_s),
        .o_rs2_s      (o_rs2_s),
        .o_rd_s       (o_rd_s),
        .o_rs1_v      (o_rs1_v),
        .o_rs2_v      (o_rs2_v),
        .o_imm        (o_imm),
        .o_funct3     (o_funct3),
        .o_alu_m1_sel (o_alu_m1_sel),
        .o_alu_m2_sel (o_alu_m2_sel),
        .o_alu_op     (o_alu_op),
        .o_cmp_m_sel  (o_cmp_m_sel),
        .o_cmp_op     (o_cmp_op),
        .o_mem_read   (o_mem_read),
        .o_mem_write  (o_mem_write),
        .o_regf_m_sel (o_regf_m_sel),
        .o_regf_we    (o_regf_we)
    );

endmodule

/* rtl/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_we,
    input  rv32i_pkg::reg_idx_t i_rd_s,
    input  rv32i_pkg::word_t    i_rd_v,
    input  rv32i_pkg::reg_idx_t i_rs1_s,
    input  rv32i_pkg::reg_idx_t i_rs2_s,
    output rv32i_pkg::word_t    o_rs1_v,
    output rv32i_pkg::word_t    o_rs2_v
);

    rv32i_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd_s != '0)) begin // x0 stays zero
            regs[i_rd_s] <= i_rd_v;
        end
    end

    // Forwarding lives in the ID/EX register
    assign o_rs1_v = regs[i_rs1_s];
    assign o_rs2_v = regs[i_rs2_s];

endmodule

/* rtl/rv32i_pkg.sv */
package rv32i_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] order_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [2:0]  alu_op_t;
    typedef logic [2:0]  cmp_op_t;
    typedef logic        alu_m1_sel_t;
    typedef logic        alu_m2_sel_t;
    typedef logic        cmp_m_sel_t;
    typedef logic [3:0]  regf_m_sel_t;

    // Opcodes kept by this stage
    localparam opcode_t OP_LUI   = 7'b0110111;
    localparam opcode_t OP_AUIPC = 7'b0010111;
    localparam opcode_t OP_IMM   = 7'b0010011;
    localparam opcode_t OP_REG   = 7'b0110011;
    localparam opcode_t OP_LOAD  = 7'b0000011;
    localparam opcode_t OP_STORE = 7'b0100011;

    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101; // SRL or SRA by funct7
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // Load widths
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // Same as funct3 except SUB and SRA
    localparam alu_op_t ALU_ADD = 3'b000;
    localparam alu_op_t ALU_SLL = 3'b001;
    localparam alu_op_t ALU_SUB = 3'b010;
    localparam alu_op_t ALU_SRA = 3'b011;
    localparam alu_op_t ALU_XOR = 3'b100;
    localparam alu_op_t ALU_SRL = 3'b101;
    localparam alu_op_t ALU_OR  = 3'b110;
    localparam alu_op_t ALU_AND = 3'b111;

    localparam cmp_op_t CMP_BLT  = 3'b100;
    localparam cmp_op_t CMP_BLTU = 3'b110;

    localparam alu_m1_sel_t M1_RS1_V  = 1'b0;
    localparam alu_m1_sel_t M1_PC     = 1'b1;
    localparam alu_m2_sel_t M2_RS2_V  = 1'b0;
    localparam alu_m2_sel_t M2_IMM    = 1'b1;
    localparam cmp_m_sel_t  CMP_RS2_V = 1'b0;
    localparam cmp_m_sel_t  CMP_IMM   = 1'b1;

    // Writeback source
    localparam regf_m_sel_t WB_ALU  = 4'd0;
    localparam regf_m_sel_t WB_CMP  = 4'd1;
    localparam regf_m_sel_t WB_UIMM = 4'd2;
    localparam regf_m_sel_t WB_LB   = 4'd3;
    localparam regf_m_sel_t WB_LH   = 4'd4;
    localparam regf_m_sel_t WB_LW   = 4'd5;
    localparam regf_m_sel_t WB_LBU  = 4'd6;
    localparam regf_m_sel_t WB_LHU  = 4'd7;

endpackage

/* tb.f */
+incdir+dv
rtl/rv32i_pkg.sv
rtl/id_decoder.sv
rtl/regfile.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
dv/tb_id_stage.sv
